// File: design/apb_reg_file.sv
`timescale 1ns/1ps

module apb_reg_file #(
    parameter logic [31:0] BASE_ADDR = 32'h0
) (
    input  logic                                  clk,
    input  logic                                  resetn,
    input  logic [uart_master_pkg::BUS_W-1:0]     paddr,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [uart_master_pkg::BUS_W-1:0]     pwdata,
    input  logic [uart_master_pkg::LANES-1:0]     pstrb,
    output logic                                  pready,
    output logic [uart_master_pkg::BUS_W-1:0]     prdata,
    output logic                                  pslverr,
    output uart_master_pkg::line_cfg_t            line_cfg,
    output uart_master_pkg::tx_req_t              tx_req,
    input  logic                                  tx_busy,
    output uart_master_pkg::line_err_t            err_clear,
    output logic [7:0]                            irq_en,
    input  uart_master_pkg::status_t              status,
    input  logic [uart_master_pkg::BUS_W-1:0]     rx_word
);
    import uart_master_pkg::*;

    logic [BUS_W-1:0] addr_off;
    reg_offset_e      offset;
    logic             in_map;
    logic             hit;
    logic             access;
    logic             is_wo;
    logic             is_ro;
    logic             wr_en;
    logic [BUS_W-1:0] baud_q;
    logic [BUS_W-1:0] control_q;
    logic [7:0]       irq_en_q;
    logic [BUS_W-1:0] tx_word_q;
    logic [BUS_W-1:0] tx_merged;
    tx_req_t          tx_req_q;
    line_err_t        err_clear_q;

    function automatic logic [BUS_W-1:0] merge_lanes(
        input logic [BUS_W-1:0] old_val,
        input logic [BUS_W-1:0] new_val,
        input logic [LANES-1:0] strb
    );
        logic [BUS_W-1:0] res;
        res = old_val;
        for (int i = 0; i < LANES; i++) begin
            if (strb[i]) begin
                res[i*BYTE_W +: BYTE_W] = new_val[i*BYTE_W +: BYTE_W];
            end
        end
        return res;
    endfunction

    assign addr_off = paddr - BASE_ADDR;
    assign offset   = reg_offset_e'(addr_off[7:0]);

    always_comb begin
        case (addr_off[7:0])
            TX_DATA, RX_DATA, BAUD, STATUS, CONTROL, STATUS_CLEAR, IRQ_EN: hit = 1'b1;
            default: hit = 1'b0;
        endcase
    end

    assign in_map = hit && (addr_off[BUS_W-1:8] == '0);
    assign access = psel && penable;
    assign is_wo  = (offset == TX_DATA) || (offset == STATUS_CLEAR);
    assign is_ro  = (offset == RX_DATA) || (offset == STATUS);

    // Only back-pressure is a TX word write while the unpacker is still sending
    assign pready  = !(access && pwrite && in_map && (offset == TX_DATA) && tx_busy);
    assign pslverr = access && (!in_map || (pwrite && is_ro) || (!pwrite && is_wo));
    assign wr_en   = access && pready && pwrite && !pslverr;

    assign tx_merged = merge_lanes(tx_word_q, pwdata, pstrb);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            baud_q      <= BAUD_RESET;
            control_q   <= CONTROL_RESET;
            irq_en_q    <= '0;
            tx_word_q   <= '0;
            tx_req_q    <= '0;
            err_clear_q <= '0;
        end else begin
            tx_req_q.valid <= 1'b0;
            err_clear_q    <= '0;
            if (wr_en) begin
                case (offset)
                    TX_DATA: begin
                        tx_word_q      <= tx_merged;
                        tx_req_q.valid <= 1'b1;
                        tx_req_q.word  <= tx_merged;
                        tx_req_q.strb  <= pstrb;
                    end
                    BAUD:    baud_q    <= merge_lanes(baud_q, pwdata, pstrb);
                    CONTROL: control_q <= merge_lanes(control_q, pwdata, pstrb);
                    STATUS_CLEAR: begin
                        if (pstrb[0]) begin
                            err_clear_q <= pwdata[7:4];
                        end
                    end
                    IRQ_EN: begin
                        if (pstrb[0]) begin
                            irq_en_q <= pwdata[7:0];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (offset)
            RX_DATA: prdata = rx_word;
            BAUD:    prdata = baud_q;
            STATUS:  prdata = {{(BUS_W-8){1'b0}}, status};
            CONTROL: prdata = control_q;
            IRQ_EN:  prdata = {{(BUS_W-8){1'b0}}, irq_en_q};
            default: prdata = '0;
        endcase
    end

    assign line_cfg.baud      = baud_q;
    assign line_cfg.parity    = parity_e'(control_q[1:0]);
    assign line_cfg.stop_bits = control_q[3:2];
    assign tx_req             = tx_req_q;
    assign err_clear          = err_clear_q;
    assign irq_en             = irq_en_q;

    // A new word must never land on an unpacker that is still busy
    a_tx_req_idle: assert property (@(posedge clk) disable iff (!resetn)
        tx_req.valid |-> !tx_busy);

endmodule

// File: design/rx_word_packer.sv
`timescale 1ns/1ps

module rx_word_packer (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic                                 rx_notempty,
    input  logic [uart_master_pkg::BYTE_W-1:0]   rx_data,
    output logic                                 rx_fifo_read_en,
    output logic [uart_master_pkg::BUS_W-1:0]    rx_word
);
    import uart_master_pkg::*;

    rx_state_e        state_q;
    logic [2:0]       count_q;
    logic [LANES-1:0] mask_q;
    logic [BUS_W-1:0] shift_q;
    logic [BUS_W-1:0] word_q;
    logic [BUS_W-1:0] commit_word;

    // Show-ahead FIFO data is valid alongside the read
    assign rx_fifo_read_en = (state_q == RX_GATHER) && rx_notempty && (count_q < LANES);
    assign rx_word         = word_q;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            commit_word[i*BYTE_W +: BYTE_W] = mask_q[i] ? shift_q[i*BYTE_W +: BYTE_W] : '0;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state_q <= RX_IDLE;
            count_q <= '0;
            mask_q  <= '0;
            shift_q <= '0;
            word_q  <= '0;
        end else begin
            case (state_q)
                RX_IDLE: begin
                    count_q <= '0;
                    mask_q  <= '0;
                    if (rx_notempty) begin
                        state_q <= RX_GATHER;
                    end
                end
                RX_GATHER: begin
                    if (rx_fifo_read_en) begin
                        shift_q <= {shift_q[BUS_W-BYTE_W-1:0], rx_data}; // Newest in 7:0
                        mask_q  <= {mask_q[LANES-2:0], 1'b1};
                        count_q <= count_q + 3'd1;
                    end else begin
                        state_q <= RX_COMMIT; // Empty or word full
                    end
                end
                RX_COMMIT: begin
                    word_q  <= commit_word;
                    state_q <= RX_IDLE;
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // An empty FIFO on the first gather cycle would commit a zero word
    a_rx_first_byte: assert property (@(posedge clk) disable iff (!resetn)
        (state_q == RX_GATHER) && (count_q == '0) |-> rx_notempty);

endmodule

// File: design/tx_word_unpacker.sv
`timescale 1ns/1ps

module tx_word_unpacker (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  uart_master_pkg::tx_req_t             tx_req,
    input  logic                                 tx_notfull,
    output logic [uart_master_pkg::BYTE_W-1:0]   tx_data,
    output logic                                 tx_fifo_write_en,
    output logic                                 tx_busy
);
    import uart_master_pkg::*;

    tx_state_e        state_q;
    logic [BUS_W-1:0] word_q;
    logic [LANES-1:0] strb_q;

    assign tx_busy          = (state_q != TX_IDLE);
    assign tx_data          = word_q[BYTE_W-1:0];
    assign tx_fifo_write_en = (state_q == TX_SEND) && tx_notfull && strb_q[0];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state_q <= TX_IDLE;
            word_q  <= '0;
            strb_q  <= '0;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    if (tx_req.valid) begin
                        word_q  <= tx_req.word;
                        strb_q  <= tx_req.strb;
                        state_q <= TX_LOAD;
                    end
                end
                TX_LOAD: state_q <= TX_SEND;
                TX_SEND: begin
                    // Stops at the first gap in the strobe
                    if (!strb_q[0]) begin
                        state_q <= TX_IDLE;
                    end else if (tx_notfull) begin
                        word_q <= word_q >> BYTE_W;
                        strb_q <= strb_q >> 1;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // A word arriving mid-send would be dropped
    a_tx_req_when_idle: assert property (@(posedge clk) disable iff (!resetn)
        tx_req.valid |-> (state_q == TX_IDLE));

endmodule

// File: design/uart_master.sv
`timescale 1ns/1ps

module uart_master #(
    parameter logic [31:0] BASE_ADDR = 32'h0
) (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic [uart_master_pkg::BUS_W-1:0]    paddr,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [uart_master_pkg::BUS_W-1:0]    pwdata,
    input  logic [uart_master_pkg::LANES-1:0]    pstrb,
    output logic                                 pready,
    output logic [uart_master_pkg::BUS_W-1:0]    prdata,
    output logic                                 pslverr,
    output logic [uart_master_pkg::BYTE_W-1:0]   tx_data,
    input  logic [uart_master_pkg::BYTE_W-1:0]   rx_data,
    output uart_master_pkg::line_cfg_t           line_cfg,
    input  uart_master_pkg::fifo_flags_t         fifo_flags,
    input  uart_master_pkg::line_err_t           raw_err,
    output logic                                 irq,
    output logic                                 tx_fifo_write_en,
    output logic                                 rx_fifo_read_en
);
    import uart_master_pkg::*;

    tx_req_t          tx_req;
    logic             tx_busy;
    line_err_t        err_clear;
    logic [7:0]       irq_en;
    status_t          status;
    logic [BUS_W-1:0] rx_word;

    apb_reg_file #(
        .BASE_ADDR (BASE_ADDR)
    ) u_apb_reg_file (
        .clk       (clk),
        .resetn    (resetn),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .pready    (pready),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .line_cfg  (line_cfg),
        .tx_req    (tx_req),
        .tx_busy   (tx_busy),
        .err_clear (err_clear),
        .irq_en    (irq_en),
        .status    (status),
        .rx_word   (rx_word)
    );

    uart_status_irq u_uart_status_irq (
        .clk        (clk),
        .resetn     (resetn),
        .raw_err    (raw_err),
        .err_clear  (err_clear),
        .fifo_flags (fifo_flags),
        .irq_en     (irq_en),
        .status     (status),
        .irq        (irq)
    );

    tx_word_unpacker u_tx_word_unpacker (
        .clk              (clk),
        .resetn           (resetn),
        .tx_req           (tx_req),
        .tx_notfull       (fifo_flags.tx_notfull),
        .tx_data          (tx_data),
        .tx_fifo_write_en (tx_fifo_write_en),
        .tx_busy          (tx_busy)
    );

    rx_word_packer u_rx_word_packer (
        .clk             (clk),
        .resetn          (resetn),
        .rx_notempty     (fifo_flags.rx_notempty),
        .rx_data         (rx_data),
        .rx_fifo_read_en (rx_fifo_read_en),
        .rx_word         (rx_word)
    );

endmodule

// File: design/uart_master_pkg.sv
package uart_master_pkg;

    localparam int BUS_W  = 32;
    localparam int BYTE_W = 8;
    localparam int LANES  = BUS_W / BYTE_W;

    // Offsets from BASE_ADDR
    typedef enum logic [7:0] {
        TX_DATA      = 8'h00, // write only
        RX_DATA      = 8'h04, // read only
        BAUD         = 8'h08,
        STATUS       = 8'h0C, // read only
        CONTROL      = 8'h10,
        STATUS_CLEAR = 8'h14, // write only, W1C strobe
        IRQ_EN       = 8'h18
    } reg_offset_e;

    typedef enum logic [1:0] {
        PAR_NONE = 2'd0,
        PAR_ODD  = 2'd1,
        PAR_EVEN = 2'd2
    } parity_e;

    typedef struct packed {
        logic [31:0] baud;
        parity_e     parity;
        logic [1:0]  stop_bits;
    } line_cfg_t;

    typedef struct packed {
        logic tx_done;
        logic tx_notfull;
        logic rx_notfull;
        logic rx_notempty;
    } fifo_flags_t;

    // Raw errors and the clear mask share this layout
    typedef struct packed {
        logic brk;
        logic frame;
        logic overrun;
        logic parity;
    } line_err_t;

    typedef struct packed {
        line_err_t   err;
        fifo_flags_t fifo;
    } status_t;

    typedef struct packed {
        logic             valid;
        logic [BUS_W-1:0] word;
        logic [LANES-1:0] strb;
    } tx_req_t;

    typedef enum logic [1:0] {
        TX_IDLE = 2'd0,
        TX_LOAD = 2'd1,
        TX_SEND = 2'd2
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE   = 2'd0,
        RX_GATHER = 2'd1,
        RX_COMMIT = 2'd2
    } rx_state_e;

    localparam logic [31:0] BAUD_RESET    = 32'h0000_0A2C;
    localparam logic [31:0] CONTROL_RESET = 32'h0000_0004; // Two stop bits, no parity

endpackage

// File: design/uart_status_irq.sv
`timescale 1ns/1ps

module uart_status_irq (
    input  logic                           clk,
    input  logic                           resetn,
    input  uart_master_pkg::line_err_t     raw_err,
    input  uart_master_pkg::line_err_t     err_clear,
    input  uart_master_pkg::fifo_flags_t   fifo_flags,
    input  logic [7:0]                     irq_en,
    output uart_master_pkg::status_t       status,
    output logic                           irq
);
    import uart_master_pkg::*;

    line_err_t err_q;
    logic      irq_q;

    // Sticky latches where a clear beats a new set
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            err_q <= '0;
        end else begin
            err_q <= (err_q | raw_err) & ~err_clear;
        end
    end

    assign status.err  = err_q;
    assign status.fifo = fifo_flags; // Live flags, not latched

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= |(status & irq_en);
        end
    end

    assign irq = irq_q;

endmodule

// File: list.f
design/uart_master_pkg.sv
design/apb_reg_file.sv
design/uart_status_irq.sv
design/tx_word_unpacker.sv
design/rx_word_packer.sv
design/uart_master.sv
verif/tb_uart_master.sv

// File: verif/tb_uart_master.sv
`timescale 1ns/1ps

module tb_uart_master;
    import uart_master_pkg::*;

    localparam logic [31:0] BASE      = 32'h4000_0000;
    localparam int          PERIOD    = 100;
    localparam int          NUM_TESTS = 5;
    localparam int          WAIT_MAX  = 100;

    logic             clk;
    logic             resetn;
    logic [31:0]      paddr;
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [31:0]      pwdata;
    logic [3:0]       pstrb;
    logic             pready;
    logic [31:0]      prdata;
    logic             pslverr;
    logic [7:0]       tx_data;
    logic [7:0]       rx_data;
    line_cfg_t        line_cfg;
    fifo_flags_t      fifo_flags;
    line_err_t        raw_err;
    logic             irq;
    logic             tx_fifo_write_en;
    logic             rx_fifo_read_en;

    integer           seed = 32'h7352;
    int               errors;
    int               checks;
    int               errors_at_start;
    int               test_num;
    string            test_name;
    int               tx_sent;
    logic [7:0]       exp_tx[$];
    logic [7:0]       rx_q[$];
    logic [7:0]       rx_ref[0:7];
    fifo_flags_t      last_flags;
    logic [31:0]      baud_m;
    logic [31:0]      control_m;
    logic [7:0]       irq_en_m;
    line_err_t        sticky_m;

    uart_master #(
        .BASE_ADDR (BASE)
    ) u_uart_master (
        .clk              (clk),
        .resetn           (resetn),
        .paddr            (paddr),
        .psel             (psel),
        .penable          (penable),
        .pwrite           (pwrite),
        .pwdata           (pwdata),
        .pstrb            (pstrb),
        .pready           (pready),
        .prdata           (prdata),
        .pslverr          (pslverr),
        .tx_data          (tx_data),
        .rx_data          (rx_data),
        .line_cfg         (line_cfg),
        .fifo_flags       (fifo_flags),
        .raw_err          (raw_err),
        .irq              (irq),
        .tx_fifo_write_en (tx_fifo_write_en),
        .rx_fifo_read_en  (rx_fifo_read_en)
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lane_merge(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    function automatic line_cfg_t cfg_from_regs(input logic [31:0] baud,
                                                input logic [31:0] control);
        line_cfg_t cfg;
        cfg.baud      = baud;
        cfg.parity    = parity_e'(control[1:0]);
        cfg.stop_bits = control[3:2];
        return cfg;
    endfunction

    // Lanes from 0 upward until the first clear strobe bit
    function automatic void model_tx_bytes(input logic [31:0] word, input logic [3:0] strb);
        for (int i = 0; i < LANES; i++) begin
            if (!strb[i]) begin
                break;
            end
            exp_tx.push_back(word[i*8 +: 8]);
        end
    endfunction

    function automatic logic [31:0] pack_rx_word(input int first, input int count);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < count; i++) begin
            w = {w[23:0], rx_ref[first + i]}; // Latest byte lands in 7:0
        end
        return w;
    endfunction

    function automatic status_t expect_status(input line_err_t sticky, input fifo_flags_t flags);
        status_t st;
        st.err  = sticky;
        st.fifo = flags;
        return st;
    endfunction

    function automatic logic expect_irq(input status_t st, input logic [7:0] en);
        return |(st & en);
    endfunction

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_cfg(input line_cfg_t got, input line_cfg_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: line_cfg got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic compare_status(input status_t got, input status_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: status got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic begin_test(input string name);
        test_num++;
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        $display("test %0d %s: %0d errors", test_num, test_name, errors - errors_at_start);
    endtask

    // Setup phase, access phase, then wait out pready
    task automatic apb_access(input logic [31:0] offset, input logic write,
                              input logic [31:0] data, input logic [3:0] strb,
                              output logic [31:0] rdata, output logic err,
                              output int waits);
        @(posedge clk);
        #1;
        paddr   = BASE + offset;
        pwrite  = write;
        pwdata  = data;
        pstrb   = write ? strb : 4'h0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waits   = 0;
        @(posedge clk);
        while (!pready && waits < WAIT_MAX) begin
            waits++;
            @(posedge clk);
        end
        if (!pready) begin
            report_error("pready stayed low for the whole wait limit");
        end
        rdata      = prdata;
        err        = pslverr;
        last_flags = fifo_flags;
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [31:0] offset, input logic [31:0] data,
                             input logic [3:0] strb, input logic exp_err);
        logic [31:0] rd;
        logic        err;
        int          waits;
        apb_access(offset, 1'b1, data, strb, rd, err, waits);
        compare_bit("pready", waits == 0, 1'b1);
        compare_bit("pslverr", err, exp_err);
    endtask

    task automatic read_reg(input logic [31:0] offset, output logic [31:0] rd,
                            input logic exp_err);
        logic err;
        int   waits;
        apb_access(offset, 1'b0, 32'h0, 4'h0, rd, err, waits);
        compare_bit("pready", waits == 0, 1'b1);
        compare_bit("pslverr", err, exp_err);
    endtask

    task automatic check_reg(input logic [31:0] offset, input logic [31:0] exp,
                             input string name);
        logic [31:0] rd;
        read_reg(offset, rd, 1'b0);
        compare_word(name, rd, exp);
    endtask

    task automatic check_status_reg();
        logic [31:0] rd;
        read_reg(STATUS, rd, 1'b0);
        compare_status(status_t'(rd[7:0]), expect_status(sticky_m, last_flags));
        compare_word("prdata[31:8]", rd >> 8, 32'h0);
    endtask

    task automatic check_irq();
        repeat (2) @(posedge clk);
        compare_bit("irq", irq, expect_irq(expect_status(sticky_m, fifo_flags), irq_en_m));
    endtask

    task automatic pulse_err(input line_err_t bits);
        @(posedge clk);
        #1 raw_err = bits;
        @(posedge clk);
        #1 raw_err = '0;
    endtask

    task automatic wait_tx_drained();
        int cnt;
        cnt = 0;
        while (exp_tx.size() != 0 && cnt < WAIT_MAX) begin
            @(posedge clk);
            cnt++;
        end
        if (exp_tx.size() != 0) begin
            report_error("transmit bytes still missing after the wait limit");
            exp_tx.delete();
        end
        repeat (4) @(posedge clk); // Room for stray bytes to show
    endtask

    task automatic load_rx(input int count);
        logic [31:0] rnd;
        @(posedge clk);
        for (int i = 0; i < count; i++) begin
            rnd       = $random(seed);
            rx_ref[i] = rnd[7:0];
            rx_q.push_back(rnd[7:0]);
        end
    endtask

    task automatic wait_rx_empty();
        int cnt;
        cnt = 0;
        while (rx_q.size() != 0 && cnt < WAIT_MAX) begin
            @(posedge clk);
            cnt++;
        end
        if (rx_q.size() != 0) begin
            report_error("receive queue was not drained by the DUT");
            rx_q.delete();
        end
        repeat (3) @(posedge clk); // Commit takes two edges
    endtask

    // Show-ahead FIFO model whose flags move 1 ns after the edge
    always @(posedge clk) begin : fifo_model
        logic       popped;
        logic [7:0] discard;
        popped = rx_fifo_read_en;
        #1;
        if (popped && rx_q.size() > 0) begin
            discard = rx_q.pop_front();
        end
        fifo_flags.tx_notfull  = ($random(seed) & 3) != 0;
        fifo_flags.rx_notempty = rx_q.size() != 0;
        rx_data                = (rx_q.size() != 0) ? rx_q[0] : 8'h00;
    end

    always @(posedge clk) begin : tx_monitor
        logic [7:0] want;
        if (resetn && tx_fifo_write_en) begin
            tx_sent++;
            if (exp_tx.size() == 0) begin
                report_error("tx_fifo_write_en high with no byte expected");
            end else begin
                want = exp_tx.pop_front();
                compare_word("tx_data", {24'h0, tx_data}, {24'h0, want});
            end
        end
    end

    initial begin : watchdog
        #(200 * NUM_TESTS * PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main
        logic [31:0] rnd;
        logic [31:0] word;
        logic [31:0] word2;
        logic [31:0] rd;
        logic [3:0]  strb;
        logic        err;
        int          waits;
        int          base;
        int          reads;
        int          cnt;
        line_err_t   err_bits;
        int          lens[4];

        resetn     = 1'b0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        pstrb      = '0;
        rx_data    = '0;
        fifo_flags = '0;
        fifo_flags.rx_notfull = 1'b1;
        raw_err    = '0;
        errors     = 0;
        checks     = 0;
        test_num   = 0;
        tx_sent    = 0;
        baud_m     = 32'h0000_0A2C;
        control_m  = 32'h0000_0004;
        irq_en_m   = 8'h00;
        sticky_m   = '0;
        repeat (8) @(posedge clk);
        #1 resetn = 1'b1;

        begin_test("reset values");
        check_reg(BAUD, baud_m, "prdata BAUD");
        check_reg(CONTROL, control_m, "prdata CONTROL");
        check_reg(IRQ_EN, {24'h0, irq_en_m}, "prdata IRQ_EN");
        check_status_reg();
        compare_cfg(line_cfg, cfg_from_regs(baud_m, control_m));
        compare_bit("irq", irq, 1'b0);
        end_test();

        begin_test("byte lanes and slave errors");
        write_reg(BAUD, 32'h1122_3344, 4'b0101, 1'b0);
        baud_m = lane_merge(baud_m, 32'h1122_3344, 4'b0101);
        check_reg(BAUD, baud_m, "prdata BAUD");
        write_reg(BAUD, 32'hDEAD_BEEF, 4'b1010, 1'b0);
        baud_m = lane_merge(baud_m, 32'hDEAD_BEEF, 4'b1010);
        check_reg(BAUD, baud_m, "prdata BAUD");
        write_reg(CONTROL, 32'hFFFF_FF09, 4'b0001, 1'b0);
        control_m = lane_merge(control_m, 32'hFFFF_FF09, 4'b0001);
        write_reg(CONTROL, 32'h0000_AB00, 4'b0010, 1'b0);
        control_m = lane_merge(control_m, 32'h0000_AB00, 4'b0010);
        check_reg(CONTROL, control_m, "prdata CONTROL");
        compare_cfg(line_cfg, cfg_from_regs(baud_m, control_m));
        write_reg(IRQ_EN, 32'h0000_005A, 4'b0001, 1'b0);
        irq_en_m = 8'h5A;
        write_reg(IRQ_EN, 32'hFFFF_FF00, 4'b1110, 1'b0); // Lane 0 untouched
        check_reg(IRQ_EN, {24'h0, irq_en_m}, "prdata IRQ_EN");
        check_irq();
        write_reg(IRQ_EN, 32'h0, 4'b0001, 1'b0);
        irq_en_m = 8'h00;
        check_irq();
        read_reg(32'h20, rd, 1'b1);
        read_reg(32'h100, rd, 1'b1);
        read_reg(TX_DATA, rd, 1'b1);
        write_reg(STATUS, 32'hFF, 4'hF, 1'b1);
        end_test();

        begin_test("transmit words");
        @(posedge clk);
        for (int i = 0; i < 6; i++) begin
            word = $random(seed);
            rnd  = $random(seed);
            strb = rnd[3:0];
            model_tx_bytes(word, strb);
            write_reg(TX_DATA, word, strb, 1'b0);
            wait_tx_drained();
        end
        word  = $random(seed);
        word2 = $random(seed);
        model_tx_bytes(word, 4'hF);
        model_tx_bytes(word2, 4'h3);
        base = tx_sent;
        apb_access(TX_DATA, 1'b1, word, 4'hF, rd, err, waits);
        compare_bit("pslverr", err, 1'b0);
        apb_access(TX_DATA, 1'b1, word2, 4'h3, rd, err, waits);
        compare_bit("pslverr", err, 1'b0);
        if (waits == 0) begin
            report_error("second TX_DATA write was accepted while the first word was sending");
        end
        compare_word("bytes sent before second word", tx_sent - base, 4);
        wait_tx_drained();
        end_test();

        begin_test("receive words");
        lens = '{1, 2, 3, 4};
        foreach (lens[i]) begin
            load_rx(lens[i]);
            wait_rx_empty();
            check_reg(RX_DATA, pack_rx_word(0, lens[i]), "prdata RX_DATA");
        end
        load_rx(6);
        reads = 0;
        cnt   = 0;
        while (reads < 4 && cnt < WAIT_MAX) begin
            @(posedge clk);
            if (rx_fifo_read_en) begin
                reads++;
            end
            cnt++;
        end
        if (reads < 4) begin
            report_error("fewer than four receive reads for the first word");
        end
        check_reg(RX_DATA, pack_rx_word(0, 4), "prdata RX_DATA");
        wait_rx_empty();
        check_reg(RX_DATA, pack_rx_word(4, 2), "prdata RX_DATA");
        end_test();

        begin_test("sticky errors and irq");
        for (int k = 0; k < 4; k++) begin
            err_bits = 4'b0001 << k;
            pulse_err(err_bits);
            sticky_m = sticky_m | err_bits;
            check_status_reg();
            check_irq();
            write_reg(IRQ_EN, 32'h10 << ((k + 1) % 4), 4'b0001, 1'b0);
            irq_en_m = 8'h10 << ((k + 1) % 4);
            check_irq();
            write_reg(IRQ_EN, 32'h10 << k, 4'b0001, 1'b0);
            irq_en_m = 8'h10 << k;
            check_irq();
            write_reg(STATUS_CLEAR, 32'h10 << k, 4'b0001, 1'b0);
            sticky_m = sticky_m & ~err_bits;
            check_status_reg();
            check_irq();
            write_reg(IRQ_EN, 32'h0, 4'b0001, 1'b0);
            irq_en_m = 8'h00;
        end
        end_test();

        $display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
